// ==== uart_top.f ====
design/uart_pkg.sv
design/uart_cfg_if.sv
design/uart_line_ctrl.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
sim/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= uart_tb
FILELIST ?= uart_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --timing
PASS_MSG ?= NO ERRORS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/uart_tb.sv ====
module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS = 6;
	localparam int NUM_BYTES = 16;
	localparam int MAX_DIV = 8;
	localparam int FLAG_LIMIT = 16 * MAX_DIV; // Cycles allowed for one frame
	localparam int WATCHDOG_NS = 2 * NUM_TESTS * NUM_BYTES * 11 * MAX_DIV * 10 + 20000;

	logic clk = 1'b0;
	logic reset_n;
	logic setting;
	logic enable;
	logic parity_en;
	logic parity_odd;
	logic [7:0] clk_div;
	logic tx_new;
	logic [7:0] tx_data;
	logic rx_ack;
	logic tx_busy;
	logic rx_new;
	logic rx_error;
	logic [7:0] rx_data;
	logic tx_line;
	logic rx_line;
	logic loopback; // DUT hears its own serial output
	logic drv_line;

	int errors = 0;
	int checks = 0;
	int test_err_base = 0;
	logic [31:0] rng_state = 32'd27603;

	assign rx_line = loopback ? tx_line : drv_line;

	uart_top #(.DIV_WIDTH(8)) dut (
		.clk(clk),
		.reset_n(reset_n),
		.setting(setting),
		.enable(enable),
		.parity_en(parity_en),
		.parity_odd(parity_odd),
		.clk_div(clk_div),
		.tx_new(tx_new),
		.tx_data(tx_data),
		.rx_ack(rx_ack),
		.tx_busy(tx_busy),
		.rx_new(rx_new),
		.rx_error(rx_error),
		.rx_data(rx_data),
		.uart_rx(rx_line),
		.uart_tx(tx_line)
	);

	always #5 clk = ~clk;

	initial begin
		#(WATCHDOG_NS);
		$display("Run timed out at %0t, the DUT stopped answering", $time);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [7:0] next_byte();
		rng_state = xorshift(rng_state);
		return rng_state[7:0];
	endfunction

	// Bit 0 is the start bit and the stop bit follows data or parity
	function automatic logic [10:0] expected_frame(input logic [7:0] data, input logic pen,
		input logic podd);
		logic [10:0] bits;
		bits = {2'b11, data, 1'b0};
		if (pen)
			bits[9] = ^data ^ podd;
		return bits;
	endfunction

	function automatic logic frame_valid(input logic [10:0] bits, input logic pen,
		input logic podd);
		logic par_ok;
		par_ok = (bits[9] == (^bits[8:1] ^ podd));
		return pen ? (bits[10] && par_ok) : bits[9];
	endfunction

	function automatic logic frame_bit(input logic [10:0] bits, input int k);
		logic [10:0] tmp;
		tmp = bits >> k;
		return tmp[0];
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic fail(input string what);
		errors++;
		$display("Failure at %0t: %s", $time, what);
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic end_test(input string name);
		$display("%s finished with %0d errors", name, errors - test_err_base);
		test_err_base = errors;
	endtask

	// Leave WORKING and pass through SETUP back to running
	task automatic configure(input int div, input logic pen, input logic podd);
		enable = 1'b0;
		setting = 1'b1;
		clk_div = 8'(div);
		parity_en = pen;
		parity_odd = podd;
		repeat (3) next_cycle();
		setting = 1'b0;
		enable = 1'b1;
		repeat (2) next_cycle();
	endtask

	task automatic wait_tx_idle();
		int n;
		n = 0;
		while (tx_busy && n < FLAG_LIMIT) begin
			next_cycle();
			n++;
		end
		if (tx_busy)
			fail("tx_busy stayed high after a whole frame");
	endtask

	task automatic send_byte(input logic [7:0] b);
		tx_data = b;
		tx_new = 1'b1;
		next_cycle();
		tx_new = 1'b0;
	endtask

	task automatic drive_frame(input logic [10:0] bits, input int nbits, input int div);
		for (int k = 0; k < nbits; k++) begin
			drv_line = frame_bit(bits, k);
			repeat (div) next_cycle();
		end
		drv_line = 1'b1;
		repeat (2) next_cycle(); // Idle gap
	endtask

	task automatic expect_rx(input logic [10:0] bits, input logic pen, input logic podd,
		input logic [7:0] old_data);
		logic ok;
		int n;
		ok = frame_valid(bits, pen, podd);
		n = 0;
		while (!rx_new && !rx_error && n < FLAG_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!rx_new && !rx_error)
			fail("neither rx_new nor rx_error rose after a frame");
		check("rx_new", 32'(rx_new), 32'(ok));
		check("rx_error", 32'(rx_error), 32'(!ok));
		check("rx_data", 32'(rx_data), ok ? 32'(bits[8:1]) : 32'(old_data));
		if (rx_new) begin
			rx_ack = 1'b1;
			next_cycle();
			rx_ack = 1'b0;
			check("rx_new after ack", 32'(rx_new), 32'd0);
		end
	endtask

	initial begin
		logic [10:0] bits;
		logic [7:0] b;
		logic [7:0] old;
		logic pen;
		logic podd;
		int div;
		int n;
		reset_n = 1'b0;
		setting = 1'b0;
		enable = 1'b0;
		parity_en = 1'b0;
		parity_odd = 1'b0;
		clk_div = '0;
		tx_new = 1'b0;
		tx_data = '0;
		rx_ack = 1'b0;
		loopback = 1'b1;
		drv_line = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;
		next_cycle();

		check("tx_busy", 32'(tx_busy), 32'd0);
		check("rx_new", 32'(rx_new), 32'd0);
		check("rx_error", 32'(rx_error), 32'd0);
		check("uart_tx", 32'(tx_line), 32'd1);
		tx_data = 8'h5a;
		tx_new = 1'b1; // Ignored while not running
		for (n = 0; n < 12; n++) begin
			next_cycle();
			check("uart_tx", 32'(tx_line), 32'd1);
			check("tx_busy", 32'(tx_busy), 32'd0);
		end
		tx_new = 1'b0;
		end_test("test 1 reset and idle line");

		configure(8, 1'b1, 1'b0);
		b = next_byte();
		bits = expected_frame(b, 1'b1, 1'b0);
		tx_data = b;
		tx_new = 1'b1;
		n = 0;
		do begin
			next_cycle();
			tx_new = 1'b0;
			n++;
			// Mid-bit of frame bit (n-1)/8
			if ((n - 1) % 8 == 4 && (n - 1) / 8 < 11)
				check($sformatf("uart_tx bit %0d", (n - 1) / 8), 32'(tx_line),
					32'(frame_bit(bits, (n - 1) / 8)));
		end while (tx_busy && n < 200);
		check("tx_busy cycles", 32'(n), 32'(11 * 8 + 1));
		expect_rx(bits, 1'b1, 1'b0, rx_data);
		end_test("test 2 transmit frame timing");

		for (int m = 0; m < 3; m++) begin
			pen = (m != 0);
			podd = (m == 2);
			div = (m == 2) ? 5 : 8;
			configure(div, pen, podd);
			for (int i = 0; i < NUM_BYTES; i++) begin
				b = next_byte();
				wait_tx_idle();
				send_byte(b);
				expect_rx(expected_frame(b, pen, podd), pen, podd, rx_data);
			end
		end
		end_test("test 3 loopback in three modes");

		// Odd parity and divisor 5 stay set from here on
		loopback = 1'b0;
		repeat (4) next_cycle();
		b = next_byte();
		bits = expected_frame(b, 1'b1, 1'b1);
		bits[9] = ~bits[9];
		old = rx_data;
		drive_frame(bits, 11, div);
		expect_rx(bits, 1'b1, 1'b1, old);
		end_test("test 4 parity error");

		b = next_byte();
		bits = expected_frame(b, 1'b1, 1'b1);
		bits[10] = 1'b0;
		old = rx_data;
		drive_frame(bits, 11, div);
		expect_rx(bits, 1'b1, 1'b1, old);
		b = next_byte();
		bits = expected_frame(b, 1'b1, 1'b1);
		drive_frame(bits, 11, div);
		expect_rx(bits, 1'b1, 1'b1, rx_data);
		end_test("test 5 stop bit error then good frame");

		repeat (div) next_cycle();
		drv_line = 1'b0;
		repeat (div / 2 - 1) next_cycle(); // Shorter than half a bit
		drv_line = 1'b1;
		repeat (12 * div) next_cycle(); // Long enough for a false frame to end
		check("rx_new after glitch", 32'(rx_new), 32'd0);
		check("rx_error after glitch", 32'(rx_error), 32'd0);
		b = next_byte();
		bits = expected_frame(b, 1'b1, 1'b1);
		drive_frame(bits, 11, div);
		expect_rx(bits, 1'b1, 1'b1, rx_data);
		end_test("test 6 start glitch");

		$display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== design/uart_top.sv ====
module uart_top #(
	parameter int DIV_WIDTH = 8
) (
	input logic clk,
	input logic reset_n,
	input logic setting,
	input logic enable,
	input logic parity_en,
	input logic parity_odd,
	input logic [DIV_WIDTH-1:0] clk_div,
	input logic tx_new,
	input logic [7:0] tx_data,
	input logic rx_ack,
	output logic tx_busy,
	output logic rx_new,
	output logic rx_error,
	output logic [7:0] rx_data,
	input logic uart_rx, // Serial in pin
	output logic uart_tx // Serial out pin
);

	uart_cfg_if #(.DIV_WIDTH(DIV_WIDTH)) cfg_if ();

	uart_line_ctrl #(.DIV_WIDTH(DIV_WIDTH)) u_line_ctrl (
		.clk(clk),
		.reset_n(reset_n),
		.setting(setting),
		.enable(enable),
		.parity_en_in(parity_en),
		.parity_odd_in(parity_odd),
		.clk_div(clk_div),
		.cfg(cfg_if.ctrl)
	);

	uart_tx #(.DIV_WIDTH(DIV_WIDTH)) u_tx (
		.clk(clk),
		.reset_n(reset_n),
		.cfg(cfg_if.user),
		.tx_new(tx_new),
		.tx_data(tx_data),
		.tx_busy(tx_busy),
		.uart_tx(uart_tx)
	);

	uart_rx #(.DIV_WIDTH(DIV_WIDTH)) u_rx (
		.clk(clk),
		.reset_n(reset_n),
		.cfg(cfg_if.user),
		.uart_rx(uart_rx),
		.rx_ack(rx_ack),
		.rx_data(rx_data),
		.rx_new(rx_new),
		.rx_error(rx_error)
	);

endmodule

// ==== design/uart_rx.sv ====
module uart_rx
	import uart_pkg::*;
#(
	parameter int DIV_WIDTH = 8
) (
	input logic clk,
	input logic reset_n,
	uart_cfg_if.user cfg,
	input logic uart_rx,
	input logic rx_ack,
	output byte_t rx_data,
	output logic rx_new,
	output logic rx_error
);

	rx_state_e state;
	logic [1:0] sync;
	logic rx_s;
	logic armed; // Line seen idle, ready for a start edge
	bit_idx_t bit_cnt;
	bit_idx_t last_bit;
	logic [DIV_WIDTH-1:0] cyc_cnt;
	logic [FRAME_BITS_PAR-1:0] frame;
	byte_t frame_data;
	logic sample;
	logic stop_ok;
	logic parity_ok;
	logic frame_ok;

	assign rx_s = sync[1];
	assign sample = (state == RX_SAMPLE) && (cyc_cnt == '0);
	assign last_bit = cfg.parity_en ? bit_idx_t'(FRAME_BITS_PAR - 1) :
		bit_idx_t'(FRAME_BITS_NOPAR - 1);

	// Frame bits land at their own index, start bit at 0
	assign frame_data = frame[8:1];
	assign stop_ok = frame[last_bit];
	assign parity_ok = !cfg.parity_en || (frame[9] == (^frame_data ^ cfg.parity_odd));
	assign frame_ok = stop_ok && parity_ok;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= RX_IDLE;
			sync <= 2'b11;
			armed <= 1'b0;
			bit_cnt <= '0;
			cyc_cnt <= '0;
			rx_new <= 1'b0;
			rx_error <= 1'b0;
		end else begin
			sync <= {sync[0], uart_rx};
			if (rx_ack)
				rx_new <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (!cfg.running) begin
						armed <= 1'b0;
					end else if (rx_s) begin
						armed <= 1'b1;
					end else if (armed) begin
						// Falling edge, wait half a bit
						state <= RX_SAMPLE;
						armed <= 1'b0;
						bit_cnt <= '0;
						cyc_cnt <= (cfg.divisor >> 1) - 1'b1;
					end
				end
				RX_SAMPLE: begin
					if (!cfg.running) begin
						state <= RX_IDLE;
					end else if (sample) begin
						if (bit_cnt == '0 && rx_s) begin
							state <= RX_IDLE; // Glitch, no flag
						end else begin
							if (bit_cnt == '0) begin
								rx_new <= 1'b0; // Real start bit
								rx_error <= 1'b0;
							end
							if (bit_cnt == last_bit) begin
								state <= RX_CHECK;
							end else begin
								bit_cnt <= bit_cnt + 1'b1;
								cyc_cnt <= cfg.divisor - 1'b1;
							end
						end
					end else begin
						cyc_cnt <= cyc_cnt - 1'b1;
					end
				end
				RX_CHECK: begin
					state <= RX_IDLE;
					if (frame_ok)
						rx_new <= 1'b1;
					else
						rx_error <= 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sample)
			frame[bit_cnt] <= rx_s;
		if (state == RX_CHECK && frame_ok)
			rx_data <= frame_data;
	end

endmodule

// ==== design/uart_tx.sv ====
module uart_tx
	import uart_pkg::*;
#(
	parameter int DIV_WIDTH = 8
) (
	input logic clk,
	input logic reset_n,
	uart_cfg_if.user cfg,
	input logic tx_new,
	input byte_t tx_data,
	output logic tx_busy,
	output logic uart_tx
);

	tx_state_e state;
	bit_idx_t bit_cnt; // Bits left after the current one
	logic [DIV_WIDTH-1:0] cyc_cnt;
	logic [9:0] shreg; // Data, parity, stop, LSB goes out first
	logic par_bit;
	logic accept;
	logic bit_end;

	assign par_bit = ^tx_data ^ cfg.parity_odd;
	assign accept = tx_new && cfg.running && !tx_busy;
	assign bit_end = (state == TX_SHIFT) && (cyc_cnt == '0);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= TX_IDLE;
			tx_busy <= 1'b0;
			uart_tx <= 1'b1;
			bit_cnt <= '0;
			cyc_cnt <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					uart_tx <= 1'b1;
					if (accept) begin
						state <= TX_SHIFT;
						tx_busy <= 1'b1;
						uart_tx <= 1'b0; // Start bit
						bit_cnt <= cfg.parity_en ? bit_idx_t'(FRAME_BITS_PAR - 1) :
							bit_idx_t'(FRAME_BITS_NOPAR - 1);
						cyc_cnt <= cfg.divisor - 1'b1;
					end
				end
				TX_SHIFT: begin
					if (!cfg.running) begin
						// Line dropped out of WORKING, abandon the frame
						state <= TX_IDLE;
						tx_busy <= 1'b0;
						uart_tx <= 1'b1;
					end else if (bit_end) begin
						if (bit_cnt == '0) begin
							state <= TX_IDLE; // Stop bit done
							tx_busy <= 1'b0;
							uart_tx <= 1'b1;
						end else begin
							uart_tx <= shreg[0];
							bit_cnt <= bit_cnt - 1'b1;
							cyc_cnt <= cfg.divisor - 1'b1;
						end
					end else begin
						cyc_cnt <= cyc_cnt - 1'b1;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	// Without parity the stop bit sits right after the data
	always_ff @(posedge clk) begin
		if (accept)
			shreg <= {1'b1, cfg.parity_en ? par_bit : 1'b1, tx_data};
		else if (bit_end)
			shreg <= shreg >> 1;
	end

endmodule

// ==== design/uart_line_ctrl.sv ====
module uart_line_ctrl
	import uart_pkg::*;
#(
	parameter int DIV_WIDTH = 8
) (
	input logic clk,
	input logic reset_n,
	input logic setting,
	input logic enable,
	input logic parity_en_in,
	input logic parity_odd_in,
	input logic [DIV_WIDTH-1:0] clk_div,
	uart_cfg_if.ctrl cfg
);

	ctrl_state_e state;
	logic [DIV_WIDTH-1:0] div_clamped;

	// Too small a divisor leaves no room for mid-bit sampling
	assign div_clamped = (clk_div < DIV_WIDTH'(MIN_DIVISOR)) ?
		DIV_WIDTH'(MIN_DIVISOR) : clk_div;

	assign cfg.running = (state == WORKING);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= IDLE;
			cfg.divisor <= '0;
			cfg.parity_en <= 1'b0;
			cfg.parity_odd <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					cfg.divisor <= '0;
					cfg.parity_en <= 1'b0;
					cfg.parity_odd <= 1'b0;
					if (setting)
						state <= SETUP;
				end
				SETUP: begin
					// Follow the host values until enable
					cfg.divisor <= div_clamped;
					cfg.parity_en <= parity_en_in;
					cfg.parity_odd <= parity_odd_in;
					if (enable)
						state <= WORKING;
				end
				WORKING: begin
					if (!enable)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== design/uart_cfg_if.sv ====
interface uart_cfg_if #(
	parameter int DIV_WIDTH = 8
);

	logic [DIV_WIDTH-1:0] divisor; // Clock cycles per bit
	logic parity_en;
	logic parity_odd;
	logic running;

	modport ctrl (
		output divisor, parity_en, parity_odd, running
	);

	modport user (
		input divisor, parity_en, parity_odd, running
	);

endinterface

// ==== design/uart_pkg.sv ====
package uart_pkg;

	// One data byte on the line
	typedef logic [7:0] byte_t;

	// Position inside a frame, start bit is 0
	typedef logic [3:0] bit_idx_t;

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		WORKING
	} ctrl_state_e;

	typedef enum logic {
		TX_IDLE,
		TX_SHIFT
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_SAMPLE,
		RX_CHECK
	} rx_state_e;

	// Start + 8 data + parity + stop
	localparam int FRAME_BITS_PAR = 11;
	localparam int FRAME_BITS_NOPAR = 10;

	// Mid-bit sampling needs a few cycles per bit
	localparam int MIN_DIVISOR = 4;

endpackage
